/* common/sd_consts.svh */
`ifndef SD_CONSTS_SVH
`define SD_CONSTS_SVH

// ----------------------------------------
// FIFO sizing
// ----------------------------------------

// Payload bits carried by each item
`define FIFO_WIDTH 8

// Number of memory entries
// Must stay a power of 2 so the pointer wrap bit works
`define FIFO_DEPTH 16

// Address bits, log2 of FIFO_DEPTH
// Pointers carry one extra bit on top of this
`define FIFO_ASZ 4

// ----------------------------------------
// Keep FIFO_ASZ in step with FIFO_DEPTH
// 8 -> 3, 16 -> 4, 32 -> 5
// ----------------------------------------

`endif

/* common/sd_pkg.sv */
`include "sd_consts.svh"

package sd_pkg;

  // ----------------------------------------
  // Data item
  // ----------------------------------------

  // One FIFO entry, tag in the upper bits
  // Tag is the sequence label set by the client
  typedef struct packed {
    logic [3:0]             tag;
    logic [`FIFO_WIDTH-1:0] payload;
  } sd_item_t;

  // ----------------------------------------
  // Pointers and counts
  // ----------------------------------------

  // Read/write pointer with wrap bit on top
  // Equal pointers mean empty, wrap bit differing means full
  typedef logic [`FIFO_ASZ:0] sd_ptr_t;

  // Memory address, pointer without the wrap bit
  typedef logic [`FIFO_ASZ-1:0] sd_addr_t;

  // Occupancy, 0 up to FIFO_DEPTH inclusive
  typedef logic [`FIFO_ASZ:0] sd_usage_t;

endpackage

/* sd_fifo/behave2p_mem.sv */
`timescale 1ns/1ps

`include "sd_consts.svh"

module behave2p_mem import sd_pkg::*;
(
  input  logic     c_clk,
  input  logic     wr_en,
  input  sd_addr_t wr_addr,
  input  sd_item_t d_in,
  input  logic     rd_en,
  input  sd_addr_t rd_addr,
  output sd_item_t d_out
);

  // Flop storage, one item per slot
  sd_item_t mem [`FIFO_DEPTH];

  // ----------------------------------------
  // Write port
  // ----------------------------------------
  always_ff @(posedge c_clk)
  begin
    if (wr_en)
      mem[wr_addr] <= d_in;
  end

  // ----------------------------------------
  // Read port
  // ----------------------------------------

  // Registered read, data valid the edge after rd_en
  // d_out holds its value while rd_en stays low
  always_ff @(posedge c_clk)
  begin
    if (rd_en)
      d_out <= mem[rd_addr];
  end

endmodule

/* sd_fifo/sd_fifo_head_s.sv */
`timescale 1ns/1ps

`include "sd_consts.svh"

module sd_fifo_head_s import sd_pkg::*;
(
  input  logic      c_clk,
  input  logic      rst_n,

  // Client write side
  input  logic      c_srdy,
  output logic      c_drdy,

  // Committed read pointer from the tail
  input  sd_ptr_t   rdptr_tail,

  // Write pointer, seen by the tail for empty
  output sd_ptr_t   wrptr_head,

  // Memory write port
  output logic      wr_en,
  output sd_addr_t  wr_addr,

  output sd_usage_t c_usage
);

  // Items stored and not yet delivered
  sd_usage_t usage;

  // ----------------------------------------
  // Occupancy
  // ----------------------------------------

  // Pointer difference, modulo 2*depth
  // Wrap bit keeps 0 and FIFO_DEPTH apart
  assign usage = wrptr_head - rdptr_tail;

  // Room while below depth
  // Only registered pointers feed this, no path from c_srdy
  assign c_drdy = (usage < sd_usage_t'(`FIFO_DEPTH));

  assign c_usage = usage;

  // ----------------------------------------
  // Memory write
  // ----------------------------------------

  // One write per accepted item
  assign wr_en = c_srdy & c_drdy;

  // Low pointer bits select the slot
  assign wr_addr = wrptr_head[`FIFO_ASZ-1:0];

  // ----------------------------------------
  // Write pointer
  // ----------------------------------------

  // Advances on each c handshake
  // Natural wrap past 2*depth
  always_ff @(posedge c_clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wrptr_head <= '0;
    end
    else if (wr_en)
    begin
      wrptr_head <= wrptr_head + sd_ptr_t'(1);
    end
  end

endmodule

/* sd_fifo/sd_fifo_tail_s.sv */
`timescale 1ns/1ps

`include "sd_consts.svh"

module sd_fifo_tail_s import sd_pkg::*;
(
  input  logic     c_clk,
  input  logic     rst_n,

  // Write pointer from the head
  input  sd_ptr_t  wrptr_head,

  // Committed read pointer, frees slots in the head
  output sd_ptr_t  rdptr_tail,

  // Memory read port
  output logic     rd_en,
  output sd_addr_t rd_addr,
  input  sd_item_t mem_data,

  // Client read side
  output logic     p_srdy,
  input  logic     p_drdy,
  output sd_item_t p_data
);

  // Next entry to fetch from memory
  sd_ptr_t pfptr;

  // Memory read register holds a fetched item
  logic rd_pend;

  // Output register empty or emptying this cycle
  logic out_free;

  // Item leaves at the p port
  logic p_xfer;

  // Memory read data moves into the output register
  logic load_out;

  // ----------------------------------------
  // Handshake decode
  // ----------------------------------------
  assign p_xfer   = p_srdy & p_drdy;
  assign out_free = ~p_srdy | p_drdy;

  // Pending item moves up once there is room
  assign load_out = rd_pend & out_free;

  // ----------------------------------------
  // Prefetch
  // ----------------------------------------

  // Fetch while unread entries exist and the output can take more
  // pfptr equal to wrptr_head means nothing left to fetch
  assign rd_en   = (pfptr != wrptr_head) & out_free;
  assign rd_addr = pfptr[`FIFO_ASZ-1:0];

  // ----------------------------------------
  // Control state
  // ----------------------------------------
  always_ff @(posedge c_clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      pfptr      <= '0;
      rdptr_tail <= '0;
      rd_pend    <= 1'b0;
      p_srdy     <= 1'b0;
    end
    else
    begin
      // Prefetch pointer runs ahead on each read
      if (rd_en)
        pfptr <= pfptr + sd_ptr_t'(1);

      // Slot released only when the item is taken
      if (p_xfer)
        rdptr_tail <= rdptr_tail + sd_ptr_t'(1);

      // New read lands, or old one stays stuck behind a full output
      rd_pend <= rd_en | (rd_pend & ~out_free);

      // Output valid follows loads and transfers
      if (load_out)
        p_srdy <= 1'b1;
      else if (p_xfer)
        p_srdy <= 1'b0;
    end
  end

  // ----------------------------------------
  // Output register
  // ----------------------------------------

  // Frozen while p_srdy high and p_drdy low
  always_ff @(posedge c_clk)
  begin
    if (load_out)
      p_data <= mem_data;
  end

endmodule

/* src/sd_fifo_s.sv */
`timescale 1ns/1ps

`include "sd_consts.svh"

module sd_fifo_s import sd_pkg::*;
(
  input  logic      c_clk,
  input  logic      rst_n,

  // Write side, items enter here
  input  logic      c_srdy,
  output logic      c_drdy,
  input  sd_item_t  c_data,
  output sd_usage_t c_usage,

  // Read side, items leave here
  output logic      p_srdy,
  input  logic      p_drdy,
  output sd_item_t  p_data
);

  // ----------------------------------------
  // Internal nets
  // ----------------------------------------

  // Pointers exchanged between head and tail
  sd_ptr_t  wrptr_head;
  sd_ptr_t  rdptr_tail;

  // Memory ports
  logic     wr_en;
  sd_addr_t wr_addr;
  logic     rd_en;
  sd_addr_t rd_addr;
  sd_item_t mem_data;

  // Write pointer, fullness and usage
  sd_fifo_head_s head (
    .c_clk      (c_clk),
    .rst_n      (rst_n),
    .c_srdy     (c_srdy),
    .c_drdy     (c_drdy),
    .rdptr_tail (rdptr_tail),
    .wrptr_head (wrptr_head),
    .wr_en      (wr_en),
    .wr_addr    (wr_addr),
    .c_usage    (c_usage)
  );

  // Item storage
  behave2p_mem mem2p (
    .c_clk   (c_clk),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .d_in    (c_data),
    .rd_en   (rd_en),
    .rd_addr (rd_addr),
    .d_out   (mem_data)
  );

  // Prefetch, output register and read pointer
  sd_fifo_tail_s tail (
    .c_clk      (c_clk),
    .rst_n      (rst_n),
    .wrptr_head (wrptr_head),
    .rdptr_tail (rdptr_tail),
    .rd_en      (rd_en),
    .rd_addr    (rd_addr),
    .mem_data   (mem_data),
    .p_srdy     (p_srdy),
    .p_drdy     (p_drdy),
    .p_data     (p_data)
  );

endmodule

/* test/tb_sd_fifo_s.sv */
`timescale 1ns/1ps

`include "sd_consts.svh"

module tb_sd_fifo_s import sd_pkg::*;
();

  // Cycles any single wait may take
  localparam int WAIT_LIMIT = 4 * `FIFO_DEPTH;

  // Length of the random traffic run
  localparam int RAND_CYCLES = 2000;

  // DUT ports
  logic      c_clk;
  logic      rst_n;
  logic      c_srdy;
  logic      c_drdy;
  sd_item_t  c_data;
  sd_usage_t c_usage;
  logic      p_srdy;
  logic      p_drdy;
  sd_item_t  p_data;

  // Model of items accepted and not yet delivered
  sd_item_t exp_q[$];
  sd_item_t exp_item;

  // Output state seen at the last sample for the hold check
  logic     hold_prev;
  sd_item_t prev_p_data;

  // Handshake counts
  int acc_count;
  int del_count;
  int acc_seen;

  // Error bookkeeping
  int err_count;
  int usage_errs;
  int tests_passed;
  int tests_failed;

  // Main sequence scratch
  int          errs_before;
  int          acc_start;
  int          del_start;
  int          waited;
  int          i;
  logic [31:0] rnd;
  sd_item_t    first_item;

  sd_fifo_s uut (
    .c_clk   (c_clk),
    .rst_n   (rst_n),
    .c_srdy  (c_srdy),
    .c_drdy  (c_drdy),
    .c_data  (c_data),
    .c_usage (c_usage),
    .p_srdy  (p_srdy),
    .p_drdy  (p_drdy),
    .p_data  (p_data)
  );

  // 20 ns period
  initial
  begin
    c_clk = 1'b0;
    forever #10 c_clk = ~c_clk;
  end

  // ----------------------------------------
  // Reporting helpers
  // ----------------------------------------

  // Wrong value on a named signal
  task report_mismatch(input string sig, input logic [31:0] exp_v, input logic [31:0] got_v);
    begin
      $display("Fail %s expected 0x%0h got 0x%0h at %0t", sig, exp_v, got_v, $time);
      err_count++;
    end
  endtask

  // Anything that is not a plain value mismatch
  task report_problem(input string msg);
    begin
      $display("Error at %0t: %s", $time, msg);
      err_count++;
    end
  endtask

  // One line per finished test
  task finish_test(input int num, input string name, input int errs);
    begin
      if (errs == 0)
      begin
        $display("Test %0d %s: ok", num, name);
        tests_passed++;
      end
      else
      begin
        $display("Test %0d %s: failed with %0d errors", num, name, errs);
        tests_failed++;
      end
    end
  endtask

  // ----------------------------------------
  // Stimulus helpers
  // ----------------------------------------

  // Step to 2 ns past the next rising edge
  task next_cycle;
    begin
      @(posedge c_clk);
      #2;
    end
  endtask

  // Fresh item whose tag counts accepted items
  task new_item;
    logic [31:0] rnd_val;
    begin
      rnd_val        = $urandom;
      c_data.tag     = acc_count[3:0];
      c_data.payload = rnd_val[`FIFO_WIDTH-1:0];
      acc_seen       = acc_count;
    end
  endtask

  // Stop the source and let the sink take everything
  task drain_fifo;
    begin
      c_srdy = 1'b0;
      p_drdy = 1'b1;
      waited = 0;
      while ((exp_q.size() != 0 || p_srdy !== 1'b0) && waited < WAIT_LIMIT)
      begin
        next_cycle();
        waited++;
      end
      if (exp_q.size() != 0 || p_srdy !== 1'b0)
        report_problem("FIFO did not drain within the wait limit");
    end
  endtask

  // ----------------------------------------
  // Monitor and model
  // ----------------------------------------

  // Sampled mid cycle with inputs and outputs settled
  always @(negedge c_clk)
  begin
    if (rst_n === 1'b1)
    begin
      // Usage counts every handshake through the last edge
      if (c_usage !== sd_usage_t'(exp_q.size()))
      begin
        usage_errs++;
        report_mismatch("c_usage", 32'(exp_q.size()), 32'(c_usage));
      end

      // Stalled output must hold still
      if (hold_prev)
      begin
        if (p_srdy !== 1'b1)
          report_problem("p_srdy dropped while p_drdy was low");
        else if (p_data !== prev_p_data)
          report_mismatch("p_data", 32'(prev_p_data), 32'(p_data));
      end

      // Delivery on the coming edge is compared against the model head
      if (p_srdy === 1'b1 && p_drdy === 1'b1)
      begin
        if (exp_q.size() == 0)
          report_problem("p side transfer while the model is empty");
        else
        begin
          exp_item = exp_q.pop_front();
          if (p_data.tag !== exp_item.tag)
            report_mismatch("p_data.tag", 32'(exp_item.tag), 32'(p_data.tag));
          if (p_data.payload !== exp_item.payload)
            report_mismatch("p_data.payload", 32'(exp_item.payload), 32'(p_data.payload));
        end
        del_count++;
      end

      // Acceptance on the coming edge
      if (c_srdy === 1'b1 && c_drdy === 1'b1)
      begin
        exp_q.push_back(c_data);
        acc_count++;
      end

      hold_prev   = (p_srdy === 1'b1) && (p_drdy !== 1'b1);
      prev_p_data = p_data;
    end
    else
      hold_prev = 1'b0;
  end

  // ----------------------------------------
  // Test sequence
  // ----------------------------------------
  initial
  begin
    void'($urandom(55));
    rst_n        = 1'b0;
    c_srdy       = 1'b0;
    p_drdy       = 1'b0;
    c_data       = '0;
    hold_prev    = 1'b0;
    prev_p_data  = '0;
    acc_count    = 0;
    del_count    = 0;
    acc_seen     = 0;
    err_count    = 0;
    usage_errs   = 0;
    tests_passed = 0;
    tests_failed = 0;

    // Test 1 checks the reset state while held and after release
    errs_before = err_count;
    repeat (3) @(posedge c_clk);
    #2;
    if (p_srdy !== 1'b0)
      report_mismatch("p_srdy", 32'h0, 32'(p_srdy));
    if (c_drdy !== 1'b1)
      report_mismatch("c_drdy", 32'h1, 32'(c_drdy));
    if (c_usage !== '0)
      report_mismatch("c_usage", 32'h0, 32'(c_usage));
    rst_n = 1'b1;
    next_cycle();
    if (p_srdy !== 1'b0)
      report_mismatch("p_srdy", 32'h0, 32'(p_srdy));
    if (c_drdy !== 1'b1)
      report_mismatch("c_drdy", 32'h1, 32'(c_drdy));
    finish_test(1, "reset state", err_count - errs_before);

    // Test 2 sends a single item through an empty FIFO
    errs_before = err_count;
    acc_start   = acc_count;
    p_drdy      = 1'b1;
    if (c_drdy !== 1'b1)
      report_mismatch("c_drdy", 32'h1, 32'(c_drdy));
    new_item();
    first_item = c_data;
    c_srdy     = 1'b1;
    // Edge k takes the item
    next_cycle();
    c_srdy = 1'b0;
    if (acc_count != acc_start + 1)
      report_problem("first item was not accepted on the first edge");
    @(negedge c_clk);
    if (p_srdy !== 1'b0)
      report_mismatch("p_srdy", 32'h0, 32'(p_srdy));
    // After k+1 the read data is still in flight
    next_cycle();
    @(negedge c_clk);
    if (p_srdy !== 1'b0)
      report_mismatch("p_srdy", 32'h0, 32'(p_srdy));
    // After k+2 the item is presented
    next_cycle();
    @(negedge c_clk);
    if (p_srdy !== 1'b1)
      report_mismatch("p_srdy", 32'h1, 32'(p_srdy));
    if (p_data !== first_item)
      report_mismatch("p_data", 32'(first_item), 32'(p_data));
    next_cycle();
    drain_fifo();
    finish_test(2, "first item latency", err_count - errs_before);

    // Test 3 fills the FIFO with the sink stalled
    errs_before = err_count;
    acc_start   = acc_count;
    p_drdy      = 1'b0;
    new_item();
    c_srdy = 1'b1;
    waited = 0;
    while (c_drdy !== 1'b0 && waited < WAIT_LIMIT)
    begin
      next_cycle();
      if (acc_count != acc_seen)
        new_item();
      waited++;
    end
    if (c_drdy !== 1'b0)
      report_problem("c_drdy never went low while filling the FIFO");
    if (acc_count - acc_start != `FIFO_DEPTH)
      report_mismatch("accepted items", 32'(`FIFO_DEPTH), 32'(acc_count - acc_start));
    // Full FIFO stays closed while the monitor checks the output hold
    repeat (5)
    begin
      next_cycle();
      if (c_drdy !== 1'b0)
        report_mismatch("c_drdy", 32'h0, 32'(c_drdy));
      if (c_usage !== sd_usage_t'(`FIFO_DEPTH))
        report_mismatch("c_usage", 32'(`FIFO_DEPTH), 32'(c_usage));
    end
    // One p transfer frees one slot
    if (p_srdy !== 1'b1)
      report_mismatch("p_srdy", 32'h1, 32'(p_srdy));
    del_start = del_count;
    c_srdy    = 1'b0;
    p_drdy    = 1'b1;
    next_cycle();
    p_drdy = 1'b0;
    if (del_count != del_start + 1)
      report_problem("single p side transfer did not happen");
    if (c_drdy !== 1'b1)
      report_mismatch("c_drdy", 32'h1, 32'(c_drdy));
    if (c_usage !== sd_usage_t'(`FIFO_DEPTH - 1))
      report_mismatch("c_usage", 32'(`FIFO_DEPTH - 1), 32'(c_usage));
    finish_test(3, "full and back-pressure", err_count - errs_before);

    // Test 4 runs random traffic in phases biased toward full then empty
    errs_before = err_count;
    del_start   = del_count;
    for (i = 0; i < RAND_CYCLES; i++)
    begin
      next_cycle();
      if (acc_count != acc_seen)
        new_item();
      rnd = $urandom;
      if (((i / 500) % 2) == 0)
      begin
        c_srdy = rnd[0] | rnd[1];
        p_drdy = rnd[2] & rnd[3];
      end
      else
      begin
        c_srdy = rnd[0] & rnd[1];
        p_drdy = rnd[2] | rnd[3];
      end
    end
    next_cycle();
    if (del_count == del_start)
      report_problem("no items were delivered during random traffic");
    finish_test(4, "order and integrity", err_count - errs_before);

    // Test 6 drains the FIFO so every accepted item comes out
    errs_before = err_count;
    drain_fifo();
    if (c_usage !== '0)
      report_mismatch("c_usage", 32'h0, 32'(c_usage));
    if (del_count != acc_count)
      report_mismatch("delivered items", 32'(acc_count), 32'(del_count));
    finish_test(6, "drain", err_count - errs_before);

    // The monitor compares usage on every cycle of the run
    finish_test(5, "usage tracking", usage_errs);

    $display("Summary: %0d passed, %0d failed, %0d errors, %0d items delivered",
             tests_passed, tests_failed, err_count, del_count);
    if (err_count == 0)
      $display("TEST PASS");
    else
      $display("TEST FAIL");
    $finish;
  end

endmodule

/* tb.f */
+incdir+common
common/sd_pkg.sv
sd_fifo/behave2p_mem.sv
sd_fifo/sd_fifo_head_s.sv
sd_fifo/sd_fifo_tail_s.sv
src/sd_fifo_s.sv
test/tb_sd_fifo_s.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the sd_fifo_s testbench with Verilator
# Exit status is nonzero when the run fails

# Work from the project root
cd "$(dirname "$0")" || exit 1

TOP=tb_sd_fifo_s
BUILD_DIR=obj_dir
BUILD_LOG=build.log
SIM_LOG=sim.log

# Compile the file list into a simulation binary
verilator --binary --timing --timescale 1ns/1ps \
  -f tb.f --top-module "$TOP" \
  --Mdir "$BUILD_DIR" -o "sim_$TOP" > "$BUILD_LOG" 2>&1
status=$?
cat "$BUILD_LOG"
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

# Run, keep the output for the search below
"./$BUILD_DIR/sim_$TOP" > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

# Verdict comes from the log
if grep -q "TEST FAIL" "$SIM_LOG"; then
  echo "Simulation reported failure, see $SIM_LOG"
  exit 1
fi

echo "Simulation finished without failure"
exit 0
